// ==== src/mips_exc_cfg.svh ====
`ifndef MIPS_EXC_CFG_SVH
`define MIPS_EXC_CFG_SVH

// Exception base while Status.BEV is set
`define EXC_BOOT_BASE    32'hBFC0_0200

`define EXC_OFS_REFILL   32'h0000_0000
`define EXC_OFS_GENERAL  32'h0000_0180
`define EXC_OFS_INT      32'h0000_0200

// Wishbone word indices of the CP0 registers
`define CP0_ADDR_W       3
`define CP0_IDX_STATUS   3'd0
`define CP0_IDX_CAUSE    3'd1
`define CP0_IDX_EPC      3'd2
`define CP0_IDX_BADVADDR 3'd3
`define CP0_IDX_EBASE    3'd4
`define CP0_IDX_ENTRYHI  3'd5

// Writable field positions
`define ST_BEV_BIT       22
`define ST_IM_HI         15
`define ST_IM_LO         8
`define ST_ERL_BIT       2
`define ST_EXL_BIT       1
`define ST_IE_BIT        0
`define CA_IV_BIT        23
`define CA_SWIP_HI       9
`define CA_SWIP_LO       8
`define EBASE_LO         12
`define ASID_HI          7

`endif

// ==== src/mips_exc_pkg.sv ====
package mips_exc_pkg;

    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        EXC_MOD  = 5'h01,
        EXC_TLBL = 5'h02,
        EXC_TLBS = 5'h03,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_RI   = 5'h0a,
        EXC_CPU  = 5'h0b,
        EXC_OV   = 5'h0c
    } exc_code_e;

    // Fault flags of the committing instruction
    typedef struct packed {
        logic iaddr_illegal;
        logic iaddr_miss;
        logic iaddr_invalid;
        logic syscall;
        logic invalid_inst;
        logic priv_inst;    // CpU
        logic overflow;
        logic eret;
        logic daddr_illegal;
        logic daddr_miss;
        logic daddr_invalid;
        logic daddr_dirty;
        logic data_we;      // Store access
    } exc_flags_t;

    typedef struct packed {
        logic        valid;
        exc_flags_t  flags;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic        in_delayslot;
        logic [7:0]  if_asid;
        logic [7:0]  mm_asid;
    } commit_t;

    typedef struct packed {
        logic        flush;
        logic        wr_exp;
        logic        clean_exl;
        exc_code_e   code;
        logic        bd;         // Faulting instruction in a delay slot
        logic [31:0] epc;
        logic [31:0] bad_vaddr;
        logic [31:0] new_pc;
        logic [7:0]  asid;
        logic        asid_valid;
    } exc_result_t;

    typedef struct packed {
        logic [8:0] zero_31_23;
        logic       bev;
        logic [5:0] zero_21_16;
        logic [7:0] im;
        logic [4:0] zero_7_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } cp0_status_t;

    typedef struct packed {
        logic       bd;
        logic [6:0] zero_30_24;
        logic       iv;
        logic [6:0] zero_22_16;
        logic [7:0] ip;         // 7:2 hardware, 1:0 software
        logic       zero_7;
        exc_code_e  exc_code;
        logic [1:0] zero_1_0;
    } cp0_cause_t;

endpackage

// ==== src/exception.sv ====
`timescale 1ns/1ps
`include "mips_exc_cfg.svh"

module exception import mips_exc_pkg::*; (
    input  commit_t     commit,
    input  cp0_status_t status,
    input  logic [7:0]  int_pend,
    input  logic        int_vec_sel,
    input  logic [19:0] ebase,
    input  logic [31:0] epc_in,
    output exc_result_t res
);

    exc_flags_t  f;
    logic [31:0] exc_base;
    logic        int_ok;
    logic        take_int;
    logic [31:0] refill_pc;

    assign f        = commit.flags;
    assign exc_base = status.bev ? `EXC_BOOT_BASE : {ebase, 12'h000};
    assign int_ok   = status.ie & ~status.exl & ~status.erl;
    assign take_int = int_ok & (|int_pend);    // int_pend already masked by IM

    // Nested TLB miss goes to the general vector
    assign refill_pc = status.exl ? exc_base + `EXC_OFS_GENERAL
                                  : exc_base + `EXC_OFS_REFILL;

    always_comb begin
        res            = '0;
        res.code       = EXC_INT;
        res.flush      = 1'b1;
        res.wr_exp     = 1'b1;
        res.bd         = commit.in_delayslot;
        res.epc        = commit.in_delayslot ? commit.pc - 32'd4 : commit.pc;
        res.new_pc     = exc_base + `EXC_OFS_GENERAL;

        if (!commit.valid) begin
            res.flush  = 1'b0;
            res.wr_exp = 1'b0;
        end else if (take_int) begin
            if (int_vec_sel)
                res.new_pc = exc_base + `EXC_OFS_INT;
        end else if (f.iaddr_illegal) begin
            res.code      = EXC_ADEL;
            res.bad_vaddr = commit.pc;
        end else if (f.iaddr_miss) begin
            res.code       = EXC_TLBL;
            res.bad_vaddr  = commit.pc;
            res.new_pc     = refill_pc;
            res.asid       = commit.if_asid;
            res.asid_valid = 1'b1;
        end else if (f.iaddr_invalid) begin
            res.code       = EXC_TLBL;
            res.bad_vaddr  = commit.pc;
            res.asid       = commit.if_asid;
            res.asid_valid = 1'b1;
        end else if (f.syscall) begin
            res.code = EXC_SYS;
        end else if (f.invalid_inst) begin
            res.code = EXC_RI;
        end else if (f.priv_inst) begin
            res.code = EXC_CPU;
        end else if (f.overflow) begin
            res.code = EXC_OV;
        end else if (f.eret) begin
            // Return only, no CP0 capture
            res.wr_exp    = 1'b0;
            res.clean_exl = 1'b1;
            res.new_pc    = epc_in;
        end else if (f.daddr_illegal) begin
            res.code      = f.data_we ? EXC_ADES : EXC_ADEL;
            res.bad_vaddr = commit.vaddr;
        end else if (f.daddr_miss) begin
            res.code       = f.data_we ? EXC_TLBS : EXC_TLBL;
            res.bad_vaddr  = commit.vaddr;
            res.new_pc     = refill_pc;
            res.asid       = commit.mm_asid;
            res.asid_valid = 1'b1;
        end else if (f.daddr_invalid) begin
            res.code       = f.data_we ? EXC_TLBS : EXC_TLBL;
            res.bad_vaddr  = commit.vaddr;
            res.asid       = commit.mm_asid;
            res.asid_valid = 1'b1;
        end else if (f.daddr_dirty) begin
            res.code       = EXC_MOD;
            res.bad_vaddr  = commit.vaddr;
            res.asid       = commit.mm_asid;
            res.asid_valid = 1'b1;
        end else begin
            res.flush  = 1'b0;
            res.wr_exp = 1'b0;
        end
    end

    // An idle commit slot must never redirect the pipeline
    always_comb begin
        if (!commit.valid)
            assert (!res.flush) else $error("flush raised without a valid commit");
    end

endmodule

// ==== src/cp0_regs.sv ====
`timescale 1ns/1ps
`include "mips_exc_cfg.svh"

module cp0_regs import mips_exc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  exc_result_t            res,
    input  logic [5:0]             hw_int,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`CP0_ADDR_W-1:0] wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    output cp0_status_t            status,
    output logic [7:0]             int_pend,
    output logic                   int_vec_sel,
    output logic [19:0]            ebase,
    output logic [31:0]            epc
);

    cp0_status_t status_q;
    cp0_cause_t  cause_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [19:0] ebase_q;
    logic [7:0]  asid_q;
    logic        ack_q;
    logic [31:0] rdata_q;
    logic [31:0] rd_mux;
    logic        bus_req;
    logic        bus_wr;
    logic        has_addr;

    // New request only outside the ack cycle
    assign bus_req = wb_cyc & wb_stb & ~ack_q;
    assign bus_wr  = bus_req & wb_we;

    always_comb begin
        case (res.code)
            EXC_MOD, EXC_TLBL, EXC_TLBS, EXC_ADEL, EXC_ADES: has_addr = 1'b1;
            default: has_addr = 1'b0;
        endcase
    end

    always_comb begin
        case (wb_adr)
            `CP0_IDX_STATUS:   rd_mux = status_q;
            `CP0_IDX_CAUSE:    rd_mux = cause_q;
            `CP0_IDX_EPC:      rd_mux = epc_q;
            `CP0_IDX_BADVADDR: rd_mux = badvaddr_q;
            `CP0_IDX_EBASE:    rd_mux = {ebase_q, 12'h000};
            `CP0_IDX_ENTRYHI:  rd_mux = {24'h0, asid_q};
            default:           rd_mux = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_req;
        end
    end

    always_ff @(posedge clk) begin
        if (bus_req)
            rdata_q <= rd_mux;    // Returned with ack
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_q     <= '0;
            status_q.bev <= 1'b1;
            cause_q      <= '0;
            epc_q        <= 32'h0;
            badvaddr_q   <= 32'h0;
            ebase_q      <= 20'h0;
            asid_q       <= 8'h0;
        end else begin
            cause_q.ip[7:2] <= hw_int;

            if (bus_wr) begin
                case (wb_adr)
                    `CP0_IDX_STATUS: begin
                        status_q.bev <= wb_dat_w[`ST_BEV_BIT];
                        status_q.im  <= wb_dat_w[`ST_IM_HI:`ST_IM_LO];
                        status_q.erl <= wb_dat_w[`ST_ERL_BIT];
                        status_q.exl <= wb_dat_w[`ST_EXL_BIT];
                        status_q.ie  <= wb_dat_w[`ST_IE_BIT];
                    end
                    `CP0_IDX_CAUSE: begin
                        cause_q.iv      <= wb_dat_w[`CA_IV_BIT];
                        cause_q.ip[1:0] <= wb_dat_w[`CA_SWIP_HI:`CA_SWIP_LO];
                    end
                    `CP0_IDX_EPC:     epc_q   <= wb_dat_w;
                    `CP0_IDX_EBASE:   ebase_q <= wb_dat_w[31:`EBASE_LO];
                    `CP0_IDX_ENTRYHI: asid_q  <= wb_dat_w[`ASID_HI:0];
                    default: ;
                endcase
            end

            // Exception side comes last and wins over the bus
            if (res.wr_exp) begin
                status_q.exl     <= 1'b1;
                cause_q.exc_code <= res.code;
                if (!status_q.exl) begin
                    epc_q      <= res.epc;
                    cause_q.bd <= res.bd;
                end
                if (has_addr)
                    badvaddr_q <= res.bad_vaddr;
                if (res.asid_valid)
                    asid_q <= res.asid;
            end

            if (res.clean_exl)
                status_q.exl <= 1'b0;    // ERET
        end
    end

    assign wb_ack      = ack_q;
    assign wb_dat_r    = rdata_q;
    assign status      = status_q;
    assign int_pend    = cause_q.ip & status_q.im;
    assign int_vec_sel = cause_q.iv;
    assign ebase       = ebase_q;
    assign epc         = epc_q;

    a_exp_eret_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(res.wr_exp && res.clean_exl));

    a_ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |-> (wb_cyc && wb_stb));

endmodule

// ==== src/exc_unit_top.sv ====
`timescale 1ns/1ps
`include "mips_exc_cfg.svh"

module exc_unit_top import mips_exc_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  commit_t                commit,
    input  logic [5:0]             hw_int,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`CP0_ADDR_W-1:0] wb_adr,
    input  logic [31:0]            wb_dat_w,
    output logic [31:0]            wb_dat_r,
    output logic                   wb_ack,
    output logic                   flush,
    output logic [31:0]            new_pc
);

    exc_result_t res;
    cp0_status_t status;
    logic [7:0]  int_pend;
    logic        int_vec_sel;
    logic [19:0] ebase;
    logic [31:0] epc;

    // Same-cycle redirect from the commit point
    exception u_exception (
        .commit      (commit),
        .status      (status),
        .int_pend    (int_pend),
        .int_vec_sel (int_vec_sel),
        .ebase       (ebase),
        .epc_in      (epc),
        .res         (res)
    );

    cp0_regs u_cp0_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .res         (res),
        .hw_int      (hw_int),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .status      (status),
        .int_pend    (int_pend),
        .int_vec_sel (int_vec_sel),
        .ebase       (ebase),
        .epc         (epc)
    );

    assign flush  = res.flush;
    assign new_pc = res.new_pc;

endmodule

// ==== sim/exc_tb.sv ====
`timescale 1ns/1ps
`include "mips_exc_cfg.svh"

module exc_tb import mips_exc_pkg::*; ();

    logic                   clk;
    logic                   rst_n;
    commit_t                cmt;
    logic [5:0]             hw_int;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [`CP0_ADDR_W-1:0] wb_adr;
    logic [31:0]            wb_dat_w;
    logic [31:0]            wb_dat_r;
    logic                   wb_ack;
    logic                   flush;
    logic [31:0]            new_pc;

    string       lines[$];
    int          err_cnt;
    int          pass_cnt;
    int          fail_cnt;
    int          cycles;
    int          limit;
    logic [31:0] lcg_state;

    exc_unit_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .commit   (cmt),
        .hw_int   (hw_int),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .flush    (flush),
        .new_pc   (new_pc)
    );

    always #50 clk = ~clk;

    // Run limit guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run went past %0d cycles", limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic int lcg_next();
        lcg_state = (lcg_state * 32'd1103515245 + 32'd12345) & 32'h7fff_ffff;
        return int'(lcg_state >> 16);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (exp !== act) begin
            $display("mismatch %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    // One Wishbone classic cycle, with a random gap in front
    task automatic bus_xfer(input string name, input logic we,
                            input logic [`CP0_ADDR_W-1:0] idx, input logic [31:0] data,
                            output logic [31:0] rdata);
        int  idle;
        int  i;
        logic got;
        idle  = lcg_next() % 4;
        got   = 1'b0;
        rdata = 32'h0;
        repeat (idle) @(posedge clk);
        @(posedge clk);
        #5;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = idx;
        wb_dat_w = data;
        for (i = 0; i < 4 && !got; i++) begin
            @(negedge clk);
            if (wb_ack) begin
                got   = 1'b1;
                rdata = wb_dat_r;
            end
        end
        @(posedge clk);
        #5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!got) begin
            $display("%s: no ack from the bus slave within 4 cycles", name);
            err_cnt++;
        end
    endtask

    task automatic do_commit(input string name, input logic [12:0] flags,
                             input logic [31:0] pc, input logic [31:0] vaddr,
                             input logic ds, input logic [7:0] if_asid,
                             input logic [7:0] mm_asid, input logic [5:0] hw,
                             input logic exp_f, input logic [31:0] exp_pc);
        @(posedge clk);
        #5;
        hw_int = hw;    // Latched into Cause.IP before the commit
        @(posedge clk);
        #5;
        cmt.valid        = 1'b1;
        cmt.flags        = flags;
        cmt.pc           = pc;
        cmt.vaddr        = vaddr;
        cmt.in_delayslot = ds;
        cmt.if_asid      = if_asid;
        cmt.mm_asid      = mm_asid;
        @(negedge clk);
        check_val(name, {31'b0, exp_f}, {31'b0, flush});
        if (exp_f)
            check_val(name, exp_pc, new_pc);
        @(posedge clk);
        #5;
        cmt = '0;
    endtask

    task automatic run_line(input string line);
        string       name;
        string       op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [31:0] vaddr;
        logic [31:0] exp_pc;
        logic [31:0] rdata;
        logic [12:0] flags;
        logic [7:0]  ia;
        logic [7:0]  ma;
        logic [5:0]  hw;
        logic        ds;
        logic        exp_f;
        int          n;
        int          err0;
        err0 = err_cnt;
        n = $sscanf(line, "%s %s", name, op);
        if (n != 2) begin
            $display("case line could not be parsed: %s", line);
            err_cnt++;
        end else if (op == "W") begin
            n = $sscanf(line, "%s %s %h %h", name, op, a, b);
            bus_xfer(name, 1'b1, a[`CP0_ADDR_W-1:0], b, rdata);
        end else if (op == "R") begin
            n = $sscanf(line, "%s %s %h %h", name, op, a, b);
            bus_xfer(name, 1'b0, a[`CP0_ADDR_W-1:0], 32'h0, rdata);
            check_val(name, b, rdata);
        end else if (op == "H") begin
            n = $sscanf(line, "%s %s %h", name, op, hw);
            @(posedge clk);
            #5;
            hw_int = hw;
        end else if (op == "C") begin
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h", name, op, flags, pc,
                        vaddr, ds, ia, ma, hw, exp_f, exp_pc);
            if (n != 11) begin
                $display("%s: commit line has missing fields", name);
                err_cnt++;
            end else begin
                do_commit(name, flags, pc, vaddr, ds, ia, ma, hw, exp_f, exp_pc);
            end
        end else begin
            $display("%s: unknown operation %s", name, op);
            err_cnt++;
        end
        if (err_cnt == err0) begin
            $display("pass %s", name);
            pass_cnt++;
        end else begin
            $display("fail %s", name);
            fail_cnt++;
        end
    endtask

    initial begin
        int    fd;
        string line;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmt       = '0;
        hw_int    = 6'h0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = 32'h0;
        err_cnt   = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        cycles    = 0;
        limit     = 0;
        lcg_state = 32'd85126;

        fd = $fopen("sim/exc_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file sim/exc_cases.txt");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                if ($fgets(line, fd) != 0) begin
                    if (line.len() > 2 && line.substr(0, 0) != "#")
                        lines.push_back(line);
                end
            end
            $fclose(fd);
            limit = 16 + 12 * lines.size();

            repeat (16) @(posedge clk);
            #5;
            rst_n = 1'b1;

            foreach (lines[i])
                run_line(lines[i]);

            $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0 && pass_cnt > 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== sim/exc_cases.txt ====
# W: name W idx data | R: name R idx expected | H: name H hw_int
# C: name C flags pc vaddr ds if_asid mm_asid hw_int exp_flush exp_new_pc
rst_status R 0 00400000
rst_cause R 1 00000000
rst_epc R 2 00000000
rst_badvaddr R 3 00000000
rst_ebase R 4 00000000
rst_entryhi R 5 00000000
bus_status_w W 0 ffffffff
bus_status_r R 0 0040ff07
bus_status_clr W 0 00400000
bus_cause_w W 1 ffffffff
bus_cause_r R 1 00800300
bus_cause_clr W 1 00000000
bus_epc_w W 2 12345678
bus_epc_r R 2 12345678
bus_bad_w W 3 ffffffff
bus_bad_r R 3 00000000
bus_ebase_w W 4 ffffffff
bus_ebase_r R 4 fffff000
bus_ehi_w W 5 ffffffff
bus_ehi_r R 5 000000ff
prio_sys C 0250 80001000 00000000 0 00 00 00 1 bfc00380
prio_sys_cause R 1 00000020
prio_sys_epc R 2 80001000
exl_clr_a W 0 00400000
prio_adel C 1a00 80002004 00000000 1 00 00 00 1 bfc00380
prio_adel_cause R 1 80000010
prio_adel_epc R 2 80002000
prio_adel_bad R 3 80002004
exl_clr_b W 0 00400000
prio_ades C 0019 80003000 00000123 0 00 00 00 1 bfc00380
prio_ades_cause R 1 00000014
prio_ades_bad R 3 00000123
exl_clr_c W 0 00400000
tlbs_refill C 000b 80004000 00401000 0 11 22 00 1 bfc00200
tlbs_cause R 1 0000000c
tlbs_bad R 3 00401000
tlbs_ehi R 5 00000022
nested_itlb C 0800 80005000 00000000 0 33 44 00 1 bfc00380
nested_epc R 2 80004000
nested_cause R 1 00000008
nested_ehi R 5 00000033
eret_epc_w W 2 8000abc0
eret C 0020 80005100 00000000 0 00 00 00 1 8000abc0
eret_status R 0 00400000
eret_cause R 1 00000008
idle_flags C 0000 80005200 00000000 0 00 00 00 0 00000000
ebase_w W 4 80010000
bev_clr W 0 00000000
gen_ebase C 0040 80006000 00000000 0 00 00 00 1 80010180
gen_ebase_cause R 1 00000030
exl_clr_d W 0 00000000
refill_ebase C 0008 80007000 00002000 0 00 55 00 1 80010000
int_enable W 0 0000fc01
int_hw C 0200 80008000 00000000 0 00 00 04 1 80010180
int_hw_cause R 1 00001000
hw_off H 00
int_enable_b W 0 0000fc01
iv_on W 1 00800000
int_iv C 0000 80009000 00000000 0 00 00 20 1 80010200
int_iv_cause R 1 00808000
int_enable_c W 0 0000fc01
sw_int_set W 1 00800100
sw_masked C 0200 8000a000 00000000 0 00 00 00 1 80010180
sw_masked_cause R 1 00800120
sw_unmask W 0 0000fd01
sw_taken C 0000 8000b000 00000000 0 00 00 00 1 80010200
int_exl_block C 0000 8000c000 00000000 0 00 00 00 0 00000000
ie_off W 0 0000fd00
int_noie C 0040 8000d000 00000000 0 00 00 00 1 80010180
final_status R 0 0000fd02

// ==== mips_exc.f ====
+incdir+src
src/mips_exc_pkg.sv
src/exception.sv
src/cp0_regs.sv
src/exc_unit_top.sv
sim/exc_tb.sv

// ==== Makefile ====
.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert -f mips_exc.f --top-module exc_tb -Mdir obj_dir

run: build
	@out="$$(./obj_dir/Vexc_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir
